// File: sim/mpx_patterns.txt
# W addr data | R addr expected_prdata | S port left right mpx_sel expected_mpx_out
# All fields hex. Port 0 is the live input, 1 playback; REG_CTRL bits 1:0 pick the source.
W 1C 00000000
W 00 00000005
R 00 00000005
W 04 00001234
R 04 00001234
W 08 89ABCDEF
R 08 89ABCDEF
W 0C 00000010
R 0C 00000010
R 10 0000807F
R 14 00000000
W 04 00000000
W 08 00000000
W 00 00000000
R 00 00000000
# Pass-through with a unity tap 0
W 18 00004000
S 0 03E8 F830 1 03E8
S 0 1234 8000 0 8000
S 0 7FFF 0001 1 7FFF
# Taps 1.5, -0.5, 0.25 with saturation at both ends
W 18 00006000
W 18 0001E000
W 18 00021000
S 0 07D0 0064 1 D045
S 0 7530 8AD0 1 7FFF
S 0 0000 8000 0 8000
S 0 0064 0003 0 22B8
# Pilot, gain 1.5, step of 1/16 turn, silent audio
W 18 00004000
W 18 00010000
W 18 00020000
W 1C 00001028
W 1C 00002064
W 1C 000030B0
W 1C 0000407F
W 04 00000180
W 08 10000000
S 0 0000 0000 0 003C
S 0 0000 0000 0 0096
S 0 0000 0000 0 FF88
S 0 0000 0000 0 00BE
W 08 00000000
S 0 7FB0 0000 1 7FFF
W 04 00000000
# Playback source, then silence codes
W 00 00000001
S 1 0123 0456 0 0456
S 1 0789 0ABC 1 0789
S 0 1111 2222 0 0000
W 00 00000002
S 0 1111 2222 0 0000
S 1 3333 4444 1 0000
W 00 00000003
S 1 3333 4444 1 0000
# Statistics over the first 4 of 6 samples
W 00 00000004
W 0C 00000004
W 00 00000008
S 0 1200 0000 1 1200
S 0 F000 0000 1 F000
S 0 3456 0000 1 3456
S 0 E5FF 0000 1 E5FF
S 0 7F00 0000 1 7F00
S 0 8000 0000 1 8000
R 10 000034E5
R 14 00000004
R 00 00000008

// File: project.f
verilog/mpx_pkg.sv
verilog/mpx_regs.sv
verilog/preemph_fir.sv
verilog/pilot_dds.sv
verilog/pilot_scaler.sv
verilog/sig_stat.sv
verilog/stereo_mpx.sv
sim/mpx_checker.sv
sim/stereo_mpx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the stereo MPX testbench with Verilator and run it from the project root.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot change to the project directory"
    exit 1
fi

verilator --binary --assert -Wno-fatal -f project.f --top-module stereo_mpx_tb \
    --Mdir obj_dir -o stereo_mpx_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/stereo_mpx_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

// File: sim/stereo_mpx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module stereo_mpx_tb import mpx_pkg::*; ();

    localparam string PATTERN_FILE    = "sim/mpx_patterns.txt";
    localparam int    CYCLES_PER_LINE = 10;
    localparam int    CYCLE_MARGIN    = 100;

    logic                        mclk;
    logic                        mreset;
    logic                        psel;
    logic                        penable;
    logic [APB_W-1:0]            paddr;
    logic                        pwrite;
    logic [APB_W-1:0]            pwdata;
    logic [APB_W-1:0]            prdata;
    logic                        pready;
    logic signed [SAMPLE_W-1:0]  in_l;
    logic signed [SAMPLE_W-1:0]  in_r;
    logic                        in_valid;
    logic signed [SAMPLE_W-1:0]  pbka_l;
    logic signed [SAMPLE_W-1:0]  pbka_r;
    logic                        pbka_valid;
    logic                        mpx_sel;
    logic signed [SAMPLE_W-1:0]  mpx_out;
    logic                        mpx_valid;

    logic [1:0] active_src;                          // Source code last written to REG_CTRL.
    int         format_errors = 0;
    int         cycle_count   = 0;
    int         cycle_limit   = 0;
    int         fd;

    stereo_mpx #(.FIR_TAPS(21)) DUT (
        .mclk(mclk), .mreset(mreset),
        .psel(psel), .penable(penable), .paddr(paddr), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .in_l(in_l), .in_r(in_r), .in_valid(in_valid),
        .pbka_l(pbka_l), .pbka_r(pbka_r), .pbka_valid(pbka_valid),
        .mpx_sel(mpx_sel), .mpx_out(mpx_out), .mpx_valid(mpx_valid)
    );

    mpx_checker u_check (
        .mclk(mclk), .mreset(mreset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .prdata(prdata), .pready(pready), .mpx_out(mpx_out), .mpx_valid(mpx_valid)
    );

    initial begin
        mclk = 1'b0;
        forever begin
            #2 mclk = ~mclk;
        end
    end

    always @(posedge mclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the pattern run did not finish", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // Inputs change 1 ns after the rising edge.
    task automatic next_cycle();
        @(posedge mclk);
        #1;
    endtask

    task automatic apb_write(input logic [APB_W-1:0] addr, input logic [APB_W-1:0] data);
        next_cycle();
        psel    = 1'b1;                              // Setup phase.
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        next_cycle();
        penable = 1'b1;                              // Access phase.
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        if (addr == REG_CTRL) begin
            active_src = data[1:0];
        end
    endtask

    task automatic apb_read(input logic [APB_W-1:0] addr, input logic [APB_W-1:0] expected);
        u_check.expect_read(expected);
        next_cycle();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        next_cycle();
        penable = 1'b1;
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Only the port picked by REG_CTRL yields an output; silence codes never match.
    task automatic send_sample(input logic [1:0] src, input logic [SAMPLE_W-1:0] left,
                               input logic [SAMPLE_W-1:0] right, input logic sel,
                               input logic [SAMPLE_W-1:0] expected);
        if (src == active_src) begin
            u_check.expect_sample(expected);
        end
        next_cycle();
        mpx_sel = sel;                               // Held until the next sample.
        if (src == SRC_LIVE) begin
            in_l     = left;
            in_r     = right;
            in_valid = 1'b1;
        end else begin
            pbka_l     = left;
            pbka_r     = right;
            pbka_valid = 1'b1;
        end
        next_cycle();
        in_valid   = 1'b0;
        pbka_valid = 1'b0;
        repeat (4) next_cycle();                     // Next strobe 6 cycles after this one.
    endtask

    task automatic bad_line(input int num);
        format_errors++;
        $display("Pattern line %0d cannot be parsed", num);
    endtask

    task automatic run_patterns();
        string       line;
        string       rest;
        int          n;
        int          line_no;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
        line_no = 0;
        while ($fgets(line, fd) > 0) begin
            line_no++;
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n" || line[0] == "\r"
                || line[0] == " ") begin
                n = 0;                               // Comment or blank line.
            end else begin
                rest = line.substr(1, line.len() - 1);
                case (line[0])
                    "W": begin
                        n = $sscanf(rest, "%h %h", f1, f2);
                        if (n == 2) apb_write(f1, f2);
                        else bad_line(line_no);
                    end
                    "R": begin
                        n = $sscanf(rest, "%h %h", f1, f2);
                        if (n == 2) apb_read(f1, f2);
                        else bad_line(line_no);
                    end
                    "S": begin
                        n = $sscanf(rest, "%h %h %h %h %h", f1, f2, f3, f4, f5);
                        if (n == 5 && f1 < 2) begin
                            send_sample(f1[1:0], f2[SAMPLE_W-1:0], f3[SAMPLE_W-1:0], f4[0],
                                        f5[SAMPLE_W-1:0]);
                        end else begin
                            bad_line(line_no);
                        end
                    end
                    default: bad_line(line_no);
                endcase
            end
        end
    endtask

    initial begin
        string line;
        int    line_count;
        int    total;
        mreset     = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        paddr      = '0;
        pwrite     = 1'b0;
        pwdata     = '0;
        in_l       = '0;
        in_r       = '0;
        in_valid   = 1'b0;
        pbka_l     = '0;
        pbka_r     = '0;
        pbka_valid = 1'b0;
        mpx_sel    = 1'b0;
        active_src = SRC_LIVE;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open pattern file %s", PATTERN_FILE);
            $display("Test failed");
            $finish;
        end else begin
            line_count = 0;
            while ($fgets(line, fd) > 0) begin
                line_count++;
            end
            $fclose(fd);
            fd = $fopen(PATTERN_FILE, "r");
            cycle_limit = CYCLES_PER_LINE * line_count + CYCLE_MARGIN;
            repeat (5) @(posedge mclk);
            #1;
            mreset = 1'b0;
            run_patterns();
            $fclose(fd);
            while (u_check.sample_q.size() != 0) begin
                @(posedge mclk);
            end
            repeat (4) @(posedge mclk);              // Room for a stray mpx_valid.
            u_check.report_leftovers();
            total = u_check.mismatch_count + u_check.other_count + format_errors;
            $display("Checked %0d reads, %0d samples; errors: %0d mismatch, %0d other, %0d format",
                     u_check.read_checks, u_check.sample_checks, u_check.mismatch_count,
                     u_check.other_count, format_errors);
            if (total == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sim/mpx_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mpx_checker import mpx_pkg::*; (
    input  logic                        mclk,
    input  logic                        mreset,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [APB_W-1:0]            paddr,
    input  logic [APB_W-1:0]            prdata,
    input  logic                        pready,
    input  logic signed [SAMPLE_W-1:0]  mpx_out,
    input  logic                        mpx_valid
);

    logic [APB_W-1:0]    read_q   [$];               // Expected prdata, in issue order.
    logic [SAMPLE_W-1:0] sample_q [$];               // Expected mpx_out, in strobe order.
    int mismatch_count = 0;
    int other_count    = 0;
    int read_checks    = 0;
    int sample_checks  = 0;

    task automatic expect_read(input logic [APB_W-1:0] value);
        read_q.push_back(value);
    endtask

    task automatic expect_sample(input logic [SAMPLE_W-1:0] value);
        sample_q.push_back(value);
    endtask

    // Access phase of any APB transfer.
    always @(posedge mclk) begin
        logic [APB_W-1:0] exp_rd;
        if (!mreset && psel && penable) begin
            if (!pready) begin
                other_count++;
                $display("APB access phase at %0t has pready low", $time);
            end
            if (!pwrite) begin
                if (read_q.size() == 0) begin
                    other_count++;
                    $display("APB read of 0x%08h at %0t had no expected value queued",
                             paddr, $time);
                end else begin
                    exp_rd = read_q.pop_front();
                    read_checks++;
                    if (prdata !== exp_rd) begin
                        mismatch_count++;
                        $display("Mismatch at %0t: read of 0x%08h gave 0x%08h, expected 0x%08h",
                                 $time, paddr, prdata, exp_rd);
                    end
                end
            end
        end
    end

    always @(posedge mclk) begin
        logic [SAMPLE_W-1:0] exp_smp;
        if (!mreset && mpx_valid) begin
            if (sample_q.size() == 0) begin
                other_count++;
                $display("mpx_valid at %0t with no expected sample pending", $time);
            end else begin
                exp_smp = sample_q.pop_front();
                sample_checks++;
                if (mpx_out !== exp_smp) begin
                    mismatch_count++;
                    $display("Mismatch at %0t: mpx_out 0x%04h (%0d), expected 0x%04h (%0d)",
                             $time, mpx_out, mpx_out, exp_smp, $signed(exp_smp));
                end
            end
        end
    end

    task automatic report_leftovers();
        if (read_q.size() != 0) begin
            other_count += read_q.size();
            $display("%0d expected APB reads were never performed", read_q.size());
        end
        if (sample_q.size() != 0) begin
            other_count += sample_q.size();
            $display("%0d expected samples never appeared on mpx_out", sample_q.size());
        end
    endtask

endmodule

`default_nettype wire

// File: verilog/stereo_mpx.sv
`timescale 1ns/1ps
`default_nettype none

module stereo_mpx import mpx_pkg::*; #(
    parameter int FIR_TAPS = 21
) (
    input  logic                         mclk,
    input  logic                         mreset,
    input  logic                         psel,
    input  logic                         penable,
    input  logic [APB_W-1:0]             paddr,
    input  logic                         pwrite,
    input  logic [APB_W-1:0]             pwdata,
    output logic [APB_W-1:0]             prdata,
    output logic                         pready,
    input  logic signed [SAMPLE_W-1:0]   in_l,
    input  logic signed [SAMPLE_W-1:0]   in_r,
    input  logic                         in_valid,
    input  logic signed [SAMPLE_W-1:0]   pbka_l,
    input  logic signed [SAMPLE_W-1:0]   pbka_r,
    input  logic                         pbka_valid,
    input  logic                         mpx_sel,
    output logic signed [SAMPLE_W-1:0]   mpx_out,
    output logic                         mpx_valid
);

    localparam logic signed [SAMPLE_W:0] OUT_HI = (1 <<< (SAMPLE_W - 1)) - 1;
    localparam logic signed [SAMPLE_W:0] OUT_LO = -(1 <<< (SAMPLE_W - 1));

    logic [1:0]                   src_sel;
    logic [GAIN_W-1:0]            pilot_gain;
    logic [PHASE_W-1:0]           dds_step;
    logic                         stat_clear;
    logic                         stat_enable;
    logic [APB_W-1:0]             stat_limit;
    logic signed [STAT_W-1:0]     stat_min;
    logic signed [STAT_W-1:0]     stat_max;
    logic [APB_W-1:0]             stat_count;
    logic                         coef_we;
    logic [COEF_IDX_W-1:0]        coef_idx;
    logic signed [COEF_W-1:0]     coef_val;
    logic                         sine_we;
    logic [TABLE_AW-1:0]          sine_idx;
    logic signed [PILOT_W-1:0]    sine_val;
    logic signed [SAMPLE_W-1:0]   sig_l;
    logic signed [SAMPLE_W-1:0]   sig_r;
    logic                         sig_valid;
    logic signed [SAMPLE_W-1:0]   fir_l;
    logic signed [SAMPLE_W-1:0]   fir_r;
    logic                         fir_l_valid;
    logic                         fir_r_valid;
    logic signed [PILOT_W-1:0]    pilot;
    logic signed [SAMPLE_W-1:0]   scaled_pilot;
    logic signed [SAMPLE_W-1:0]   mix;
    logic                         mix_valid;
    logic signed [SAMPLE_W:0]     sum;

    always_comb begin
        case (src_sel)
            SRC_LIVE: begin
                sig_l     = in_l;
                sig_r     = in_r;
                sig_valid = in_valid;
            end
            SRC_PLAYBACK: begin
                sig_l     = pbka_l;
                sig_r     = pbka_r;
                sig_valid = pbka_valid;
            end
            default: begin                                // Muted, no strobe goes on.
                sig_l     = '0;
                sig_r     = '0;
                sig_valid = 1'b0;
            end
        endcase
    end

    mpx_regs u_regs (
        .mclk(mclk), .mreset(mreset),
        .psel(psel), .penable(penable), .paddr(paddr), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .src_sel(src_sel), .pilot_gain(pilot_gain), .dds_step(dds_step),
        .stat_clear(stat_clear), .stat_enable(stat_enable), .stat_limit(stat_limit),
        .coef_we(coef_we), .coef_idx(coef_idx), .coef_val(coef_val),
        .sine_we(sine_we), .sine_idx(sine_idx), .sine_val(sine_val),
        .stat_min(stat_min), .stat_max(stat_max), .stat_count(stat_count)
    );

    preemph_fir #(.FIR_TAPS(FIR_TAPS)) preemph_l (
        .mclk(mclk), .mreset(mreset),
        .coef_we(coef_we), .coef_idx(coef_idx), .coef_val(coef_val),
        .in(sig_l), .valid_in(sig_valid), .out(fir_l), .valid_out(fir_l_valid)
    );

    preemph_fir #(.FIR_TAPS(FIR_TAPS)) preemph_r (
        .mclk(mclk), .mreset(mreset),
        .coef_we(coef_we), .coef_idx(coef_idx), .coef_val(coef_val),
        .in(sig_r), .valid_in(sig_valid), .out(fir_r), .valid_out(fir_r_valid)
    );

    pilot_dds u_dds (
        .mclk(mclk), .mreset(mreset),
        .sine_we(sine_we), .sine_idx(sine_idx), .sine_val(sine_val),
        .sync(sig_valid), .step(dds_step), .pilot(pilot)
    );

    pilot_scaler #(
        .IN_W(PILOT_W), .GAIN_W(GAIN_W), .OUT_W(SAMPLE_W), .FRAC(GAIN_FRAC)
    ) u_scaler (
        .mclk(mclk), .pilot(pilot), .gain(pilot_gain), .scaled(scaled_pilot)
    );

    assign sum = mix + scaled_pilot;                      // One guard bit for the clamp.

    always_ff @(posedge mclk) begin
        if (mreset) begin
            mix       <= '0;
            mix_valid <= 1'b0;
            mpx_out   <= '0;
            mpx_valid <= 1'b0;
        end else begin
            mix_valid <= fir_l_valid && fir_r_valid;
            if (fir_l_valid && fir_r_valid) begin
                mix <= mpx_sel ? fir_l : fir_r;
            end
            mpx_valid <= mix_valid;
            if (sum > OUT_HI) begin
                mpx_out <= OUT_HI[SAMPLE_W-1:0];
            end else if (sum < OUT_LO) begin
                mpx_out <= OUT_LO[SAMPLE_W-1:0];
            end else begin
                mpx_out <= sum[SAMPLE_W-1:0];
            end
        end
    end

    // Statistics see the upper byte; reset also brings them to the cleared state.
    sig_stat #(.SIG_W(STAT_W), .CNT_W(APB_W)) u_stat (
        .mclk(mclk), .clear(stat_clear || mreset), .enable(stat_enable),
        .sig(mpx_out[SAMPLE_W-1 -: STAT_W]), .sig_valid(mpx_valid),
        .limit(stat_limit), .min(stat_min), .max(stat_max), .count(stat_count)
    );

endmodule

`default_nettype wire

// File: verilog/sig_stat.sv
`timescale 1ns/1ps
`default_nettype none

module sig_stat #(
    parameter int SIG_W = 8,
    parameter int CNT_W = 32
) (
    input  logic                     mclk,
    input  logic                     clear,
    input  logic                     enable,
    input  logic signed [SIG_W-1:0]  sig,
    input  logic                     sig_valid,
    input  logic [CNT_W-1:0]         limit,
    output logic signed [SIG_W-1:0]  min,
    output logic signed [SIG_W-1:0]  max,
    output logic [CNT_W-1:0]         count
);

    localparam logic signed [SIG_W-1:0] SIG_HI = (1 <<< (SIG_W - 1)) - 1;
    localparam logic signed [SIG_W-1:0] SIG_LO = -(1 <<< (SIG_W - 1));

    logic take;

    assign take = enable && sig_valid && (count < limit);

    always_ff @(posedge mclk) begin
        if (clear) begin
            min   <= SIG_HI;                              // Any sample replaces these.
            max   <= SIG_LO;
            count <= '0;
        end else if (take) begin
            if (sig < min) begin
                min <= sig;
            end
            if (sig > max) begin
                max <= sig;
            end
            count <= count + 1'b1;
        end
    end

    // Capture stops at the limit for as long as it runs.
    a_count_within_limit: assert property (
        @(posedge mclk) disable iff (clear || !enable) count <= limit
    );

endmodule

`default_nettype wire

// File: verilog/pilot_scaler.sv
`timescale 1ns/1ps
`default_nettype none

module pilot_scaler import mpx_pkg::*; #(
    parameter int IN_W   = PILOT_W,
    parameter int GAIN_W = 16,
    parameter int OUT_W  = SAMPLE_W,
    parameter int FRAC   = GAIN_FRAC
) (
    input  logic                     mclk,
    input  logic signed [IN_W-1:0]   pilot,
    input  logic [GAIN_W-1:0]        gain,
    output logic signed [OUT_W-1:0]  scaled
);

    localparam int PROD_W = IN_W + GAIN_W + 1;          // Gain gets a zero sign bit.
    localparam logic signed [PROD_W-1:0] OUT_HI = (1 <<< (OUT_W - 1)) - 1;
    localparam logic signed [PROD_W-1:0] OUT_LO = -(1 <<< (OUT_W - 1));

    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] prod_sh;

    assign prod    = pilot * $signed({1'b0, gain});
    assign prod_sh = prod >>> FRAC;

    always_ff @(posedge mclk) begin
        if (prod_sh > OUT_HI) begin
            scaled <= OUT_HI[OUT_W-1:0];
        end else if (prod_sh < OUT_LO) begin
            scaled <= OUT_LO[OUT_W-1:0];
        end else begin
            scaled <= prod_sh[OUT_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: verilog/pilot_dds.sv
`timescale 1ns/1ps
`default_nettype none

module pilot_dds import mpx_pkg::*; (
    input  logic                        mclk,
    input  logic                        mreset,
    input  logic                        sine_we,
    input  logic [TABLE_AW-1:0]         sine_idx,
    input  logic signed [PILOT_W-1:0]   sine_val,
    input  logic                        sync,
    input  logic [PHASE_W-1:0]          step,
    output logic signed [PILOT_W-1:0]   pilot
);

    logic signed [PILOT_W-1:0] sine_tab [2**TABLE_AW];
    logic [PHASE_W-1:0]        phase;
    logic [PHASE_W-1:0]        phase_next;

    assign phase_next = phase + step;                  // Wraps modulo 2^32.

    always_ff @(posedge mclk) begin
        if (sine_we) begin
            sine_tab[sine_idx] <= sine_val;
        end
    end

    // Lookup uses the advanced phase so pilot lines up with the FIR output.
    always_ff @(posedge mclk) begin
        if (mreset) begin
            phase <= '0;
            pilot <= '0;
        end else if (sync) begin
            phase <= phase_next;
            pilot <= sine_tab[phase_next[PHASE_W-1 -: TABLE_AW]];
        end
    end

endmodule

`default_nettype wire

// File: verilog/preemph_fir.sv
`timescale 1ns/1ps
`default_nettype none

module preemph_fir import mpx_pkg::*; #(
    parameter int FIR_TAPS = 21
) (
    input  logic                         mclk,
    input  logic                         mreset,
    input  logic                         coef_we,
    input  logic [COEF_IDX_W-1:0]        coef_idx,
    input  logic signed [COEF_W-1:0]     coef_val,
    input  logic signed [SAMPLE_W-1:0]   in,
    input  logic                         valid_in,
    output logic signed [SAMPLE_W-1:0]   out,
    output logic                         valid_out
);

    // Headroom for up to 32 full-scale products.
    localparam int ACC_W = SAMPLE_W + COEF_W + COEF_IDX_W;
    localparam logic signed [ACC_W-1:0] SAT_HI = (1 <<< (SAMPLE_W - 1)) - 1;
    localparam logic signed [ACC_W-1:0] SAT_LO = -(1 <<< (SAMPLE_W - 1));

    logic signed [COEF_W-1:0]   coefs [FIR_TAPS];
    logic signed [SAMPLE_W-1:0] dly   [FIR_TAPS-1];      // Past samples, newest first.
    logic signed [SAMPLE_W-1:0] taps  [FIR_TAPS];
    logic signed [ACC_W-1:0]    acc;
    logic signed [ACC_W-1:0]    acc_sh;

    // The incoming sample takes part in this cycle's sum.
    always_comb begin
        taps[0] = in;
        for (int k = 1; k < FIR_TAPS; k++) begin
            taps[k] = dly[k-1];
        end
    end

    always_comb begin
        acc = '0;
        for (int k = 0; k < FIR_TAPS; k++) begin
            acc = acc + taps[k] * coefs[k];
        end
        acc_sh = acc >>> COEF_FRAC;                      // Drop the Q1.14 fraction.
    end

    always_ff @(posedge mclk) begin
        if (mreset) begin
            for (int k = 0; k < FIR_TAPS; k++) begin
                coefs[k] <= '0;
            end
            for (int k = 0; k < FIR_TAPS - 1; k++) begin
                dly[k] <= '0;
            end
            out       <= '0;
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
            if (coef_we) begin
                coefs[coef_idx] <= coef_val;
            end
            if (valid_in) begin
                dly[0] <= in;
                for (int k = 1; k < FIR_TAPS - 1; k++) begin
                    dly[k] <= dly[k-1];
                end
                if (acc_sh > SAT_HI) begin
                    out <= SAT_HI[SAMPLE_W-1:0];
                end else if (acc_sh < SAT_LO) begin
                    out <= SAT_LO[SAMPLE_W-1:0];
                end else begin
                    out <= acc_sh[SAMPLE_W-1:0];
                end
            end
        end
    end

    // Tap index from the register file must fit this filter's length.
    a_coef_idx_in_range: assert property (
        @(posedge mclk) disable iff (mreset) coef_we |-> (coef_idx < FIR_TAPS)
    );

endmodule

`default_nettype wire

// File: verilog/mpx_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mpx_regs import mpx_pkg::*; (
    input  logic                         mclk,
    input  logic                         mreset,
    input  logic                         psel,
    input  logic                         penable,
    input  logic [APB_W-1:0]             paddr,
    input  logic                         pwrite,
    input  logic [APB_W-1:0]             pwdata,
    output logic [APB_W-1:0]             prdata,
    output logic                         pready,
    output logic [1:0]                   src_sel,
    output logic [GAIN_W-1:0]            pilot_gain,
    output logic [PHASE_W-1:0]           dds_step,
    output logic                         stat_clear,
    output logic                         stat_enable,
    output logic [APB_W-1:0]             stat_limit,
    output logic                         coef_we,
    output logic [COEF_IDX_W-1:0]        coef_idx,
    output logic signed [COEF_W-1:0]     coef_val,
    output logic                         sine_we,
    output logic [TABLE_AW-1:0]          sine_idx,
    output logic signed [PILOT_W-1:0]    sine_val,
    input  logic signed [STAT_W-1:0]     stat_min,
    input  logic signed [STAT_W-1:0]     stat_max,
    input  logic [APB_W-1:0]             stat_count
);

    logic             wr_acc;
    logic             rd_setup;
    logic [APB_W-1:0] rdata;

    assign wr_acc   = psel && penable && pwrite;   // Write lands at end of access.
    assign rd_setup = psel && !penable && !pwrite; // Read data captured in setup.

    always_comb begin
        case (paddr)
            REG_CTRL:   rdata = {{(APB_W-4){1'b0}}, stat_enable, stat_clear, src_sel};
            REG_GAIN:   rdata = {{(APB_W-GAIN_W){1'b0}}, pilot_gain};
            REG_STEP:   rdata = dds_step;
            REG_LIMIT:  rdata = stat_limit;
            REG_MINMAX: rdata = {{(APB_W-2*STAT_W){1'b0}}, stat_max, stat_min};
            REG_COUNT:  rdata = stat_count;
            default:    rdata = '0;                  // Load ports read as zero.
        endcase
    end

    always_ff @(posedge mclk) begin
        if (mreset) begin
            prdata      <= '0;
            pready      <= 1'b0;
            src_sel     <= SRC_LIVE;
            pilot_gain  <= '0;
            dds_step    <= '0;
            stat_clear  <= 1'b0;
            stat_enable <= 1'b0;
            stat_limit  <= '0;
            coef_we     <= 1'b0;
            coef_idx    <= '0;
            coef_val    <= '0;
            sine_we     <= 1'b0;
            sine_idx    <= '0;
            sine_val    <= '0;
        end else begin
            pready  <= psel && !penable;             // High for every access phase.
            coef_we <= wr_acc && (paddr == REG_COEF);
            sine_we <= wr_acc && (paddr == REG_SINE);
            if (rd_setup) begin
                prdata <= rdata;
            end
            if (wr_acc) begin
                case (paddr)
                    REG_CTRL: begin
                        src_sel     <= pwdata[1:0];
                        stat_clear  <= pwdata[2];
                        stat_enable <= pwdata[3];
                    end
                    REG_GAIN:  pilot_gain <= pwdata[GAIN_W-1:0];
                    REG_STEP:  dds_step   <= pwdata[PHASE_W-1:0];
                    REG_LIMIT: stat_limit <= pwdata;
                    REG_COEF: begin
                        coef_idx <= pwdata[16 +: COEF_IDX_W];
                        coef_val <= pwdata[COEF_W-1:0];
                    end
                    REG_SINE: begin
                        sine_idx <= pwdata[8 +: TABLE_AW];
                        sine_val <= pwdata[PILOT_W-1:0];
                    end
                    default: ;
                endcase
            end
        end
    end

    // APB protocol: the access phase always follows a setup with psel held.
    a_penable_needs_psel: assert property (
        @(posedge mclk) disable iff (mreset) penable |-> psel
    );

endmodule

`default_nettype wire

// File: verilog/mpx_pkg.sv
`default_nettype none

package mpx_pkg;

    // Datapath widths.
    localparam int SAMPLE_W   = 16;            // Audio and MPX samples.
    localparam int PILOT_W    = 8;             // Pilot table entries.
    localparam int COEF_W     = 16;            // FIR taps, signed Q1.14.
    localparam int COEF_FRAC  = 14;
    localparam int GAIN_W     = 16;            // Pilot gain, unsigned Q8.8.
    localparam int GAIN_FRAC  = 8;
    localparam int PHASE_W    = 32;            // DDS accumulator.
    localparam int TABLE_AW   = 8;             // 256-entry sine table.
    localparam int STAT_W     = 8;             // Upper byte of the output.
    localparam int COEF_IDX_W = 5;             // Up to 32 taps.
    localparam int APB_W      = 32;

    // Source select codes; anything else mutes the chain.
    localparam logic [1:0] SRC_LIVE     = 2'd0;
    localparam logic [1:0] SRC_PLAYBACK = 2'd1;

    // APB register map, byte addresses.
    localparam logic [APB_W-1:0] REG_CTRL   = 32'h00;
    localparam logic [APB_W-1:0] REG_GAIN   = 32'h04;
    localparam logic [APB_W-1:0] REG_STEP   = 32'h08;
    localparam logic [APB_W-1:0] REG_LIMIT  = 32'h0C;
    localparam logic [APB_W-1:0] REG_MINMAX = 32'h10;
    localparam logic [APB_W-1:0] REG_COUNT  = 32'h14;
    localparam logic [APB_W-1:0] REG_COEF   = 32'h18;
    localparam logic [APB_W-1:0] REG_SINE   = 32'h1C;

endpackage

`default_nettype wire
